// File: source/zxuno_pkg.sv
package zxuno_pkg;

  // ------------------------------
  // I/O ports and bus defaults
  // ------------------------------

  // Register number select, readable back
  localparam logic [15:0] ADDR_PORT = 16'hFC3B;
  // Data access to the selected register
  localparam logic [15:0] DATA_PORT = 16'hFD3B;

  // Floating bus value when nobody answers
  localparam logic [7:0] NO_DRIVER_VALUE = 8'hFF;

  // Longest core ID string, in characters
  localparam int CORE_ID_MAX = 16;

  // String literal is right justified, zero filled on the left
  localparam logic [CORE_ID_MAX*8-1:0] DEFAULT_CORE_ID = "T01ZX";

  // ------------------------------
  // Encodings
  // ------------------------------

  typedef enum logic [7:0] {
    REG_SCANDBL = 8'h0B,
    REG_DEVOPTS = 8'h0E,
    REG_SCRATCH = 8'hFE,
    REG_COREID  = 8'hFF
  } reg_num_e;

  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1
  } access_state_e;

  // ------------------------------
  // Bundles
  // ------------------------------

  // Z80 style I/O bus, control lines active low
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
  } io_bus_t;

  // Register access towards the datapath blocks
  typedef struct packed {
    reg_num_e   reg_num;
    logic [7:0] wdata;
    logic       rd_stb;
    logic       wr_stb;
  } reg_access_t;

  typedef struct packed {
    logic [7:0] data;
    logic       oe;
  } readback_t;

  // Register 0B, bits 5..0
  typedef struct packed {
    logic       csync_option;
    logic [2:0] freq_option;
    logic       scanlines_enable;
    logic       vga_enable;
  } video_opts_t;

  // Register 0E, disable_ay in bit 0 up to disable_ulaplus in bit 7
  typedef struct packed {
    logic disable_ulaplus;
    logic disable_spisd;
    logic disable_romsel1f;
    logic disable_romsel7f;
    logic disable_1ffd;
    logic disable_7ffd;
    logic disable_turboay;
    logic disable_ay;
  } device_opts_t;

endpackage

// File: source/port_access_ctrl.sv
`timescale 1ns/1ps

module port_access_ctrl (
  input  logic                    sysclk,
  input  logic                    reset,
  input  zxuno_pkg::io_bus_t      bus,
  input  zxuno_pkg::readback_t    coreid_rb,
  input  zxuno_pkg::readback_t    option_rb,
  output zxuno_pkg::reg_access_t  access,
  output logic [7:0]              din,
  output logic                    oe
);
  import zxuno_pkg::*;

  access_state_e state;
  io_bus_t       bus_q;
  logic          first_q;
  reg_num_e      reg_num_q;
  logic          bus_active;
  logic          addr_hit;
  logic          data_hit;
  logic          rd_cyc;
  logic          wr_cyc;
  readback_t     sel_rb;

  // Exactly one of rd_n / wr_n low together with iorq_n
  assign bus_active = !bus.iorq_n && (bus.rd_n != bus.wr_n);

  // Decode on the sampled bus, full 16 bit compare
  assign addr_hit = (bus_q.addr == ADDR_PORT);
  assign data_hit = (bus_q.addr == DATA_PORT);

  // First cycle after the access was taken
  assign rd_cyc = first_q && !bus_q.rd_n;
  assign wr_cyc = first_q && !bus_q.wr_n;

  // ------------------------------
  // Access tracking
  // ------------------------------

  always_ff @(posedge sysclk) begin
    if (reset) begin
      state   <= IDLE;
      first_q <= 1'b0;
      bus_q   <= '{addr: '0, wdata: '0, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
    end else begin
      bus_q   <= bus;
      first_q <= 1'b0;
      case (state)
        IDLE: begin
          if (bus_active) begin
            state   <= BUSY;
            first_q <= 1'b1;
          end
        end
        BUSY: begin
          // Stays here until the bus drops, one strobe per access
          if (!bus_active) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Register number latch
  always_ff @(posedge sysclk) begin
    if (reset) begin
      reg_num_q <= reg_num_e'(8'h00);
    end else if (wr_cyc && addr_hit) begin
      reg_num_q <= reg_num_e'(bus_q.wdata);
    end
  end

  // ------------------------------
  // Strobes to the datapath
  // ------------------------------

  always_comb begin
    access.reg_num = reg_num_q;
    // During an address write show a number that surely differs from the
    // incoming one, so a rewrite of the same number still looks like a change
    if (wr_cyc && addr_hit) begin
      access.reg_num = reg_num_e'(~bus_q.wdata);
    end
    access.wdata  = bus_q.wdata;
    access.rd_stb = rd_cyc && data_hit;
    access.wr_stb = wr_cyc && data_hit;
  end

  // Read data priority
  always_comb begin
    if (addr_hit) begin
      sel_rb = '{data: reg_num_q, oe: 1'b1};
    end else if (data_hit && coreid_rb.oe) begin
      sel_rb = coreid_rb;
    end else if (data_hit && option_rb.oe) begin
      sel_rb = option_rb;
    end else begin
      sel_rb = '{data: NO_DRIVER_VALUE, oe: 1'b0};
    end
  end

  // Read data held until the access ends
  always_ff @(posedge sysclk) begin
    if (reset) begin
      din <= NO_DRIVER_VALUE;
      oe  <= 1'b0;
    end else if (state == BUSY && !bus_active) begin
      oe <= 1'b0;
    end else if (rd_cyc) begin
      din <= sel_rb.data;
      oe  <= sel_rb.oe;
    end
  end

endmodule

// File: source/coreid_reader.sv
`timescale 1ns/1ps

module coreid_reader #(
  parameter logic [zxuno_pkg::CORE_ID_MAX*8-1:0] CORE_ID = zxuno_pkg::DEFAULT_CORE_ID
) (
  input  logic                   sysclk,
  input  logic                   reset,
  input  zxuno_pkg::reg_access_t access,
  output zxuno_pkg::readback_t   rb
);
  import zxuno_pkg::*;

  // Characters in use, counted up to the highest non zero byte
  function automatic int id_length(logic [CORE_ID_MAX*8-1:0] s);
    int len;
    len = 0;
    for (int i = 0; i < CORE_ID_MAX; i++) begin
      if (s[i*8 +: 8] != 8'h00) begin
        len = i + 1;
      end
    end
    return len;
  endfunction

  localparam int ID_LEN = id_length(CORE_ID);
  localparam int IDX_W  = $clog2(CORE_ID_MAX + 1);

  // First character sits in the highest used byte
  function automatic logic [7:0] char_at(logic [IDX_W-1:0] i);
    if (int'(i) < ID_LEN) begin
      return CORE_ID[(ID_LEN - 1 - int'(i))*8 +: 8];
    end
    return 8'h00;
  endfunction

  logic [IDX_W-1:0] idx;
  reg_num_e         reg_num_q;

  always_ff @(posedge sysclk) begin
    if (reset) begin
      idx       <= '0;
      reg_num_q <= reg_num_e'(8'h00);
    end else begin
      reg_num_q <= access.reg_num;
      if (access.reg_num != reg_num_q) begin
        idx <= '0;
      end else if (access.rd_stb && access.reg_num == REG_COREID &&
                   idx != IDX_W'(CORE_ID_MAX)) begin
        idx <= idx + 1'b1;
      end
    end
  end

  assign rb.data = char_at(idx);
  assign rb.oe   = (access.reg_num == REG_COREID);

endmodule

// File: source/option_registers.sv
`timescale 1ns/1ps

module option_registers (
  input  logic                    sysclk,
  input  logic                    reset,
  input  logic                    turbo_boost,
  input  zxuno_pkg::reg_access_t  access,
  output zxuno_pkg::readback_t    rb,
  output zxuno_pkg::video_opts_t  video_opts,
  output zxuno_pkg::device_opts_t device_opts,
  output logic [1:0]              cpu_speed
);
  import zxuno_pkg::*;

  logic [7:0] scratch_q;
  logic [7:0] scandbl_q;
  logic [7:0] devopts_q;

  // ------------------------------
  // Register writes
  // ------------------------------

  always_ff @(posedge sysclk) begin
    if (reset) begin
      scratch_q <= 8'h00;
      scandbl_q <= 8'h00;
      devopts_q <= 8'h00;
    end else if (access.wr_stb) begin
      case (access.reg_num)
        REG_SCRATCH: scratch_q <= access.wdata;
        REG_SCANDBL: scandbl_q <= access.wdata;
        REG_DEVOPTS: devopts_q <= access.wdata;
        default: ;
      endcase
    end
  end

  // Readback always shows the stored byte
  always_comb begin
    case (access.reg_num)
      REG_SCRATCH: rb = '{data: scratch_q, oe: 1'b1};
      REG_SCANDBL: rb = '{data: scandbl_q, oe: 1'b1};
      REG_DEVOPTS: rb = '{data: devopts_q, oe: 1'b1};
      default:     rb = '{data: NO_DRIVER_VALUE, oe: 1'b0};
    endcase
  end

  // ------------------------------
  // Decoded outputs
  // ------------------------------

  assign video_opts  = video_opts_t'(scandbl_q[5:0]);
  assign device_opts = device_opts_t'(devopts_q);

  // Keyboard turbo key forces the fastest speed code
  assign cpu_speed = turbo_boost ? 2'b11 : scandbl_q[7:6];

endmodule

// File: source/zxuno_regs_top.sv
`timescale 1ns/1ps

module zxuno_regs_top #(
  parameter logic [zxuno_pkg::CORE_ID_MAX*8-1:0] CORE_ID = zxuno_pkg::DEFAULT_CORE_ID
) (
  input  logic                    sysclk,
  input  logic                    reset,
  input  zxuno_pkg::io_bus_t      bus,
  input  logic                    turbo_boost,
  output logic [7:0]              din,
  output logic                    oe,
  output zxuno_pkg::video_opts_t  video_opts,
  output zxuno_pkg::device_opts_t device_opts,
  output logic [1:0]              cpu_speed
);
  import zxuno_pkg::*;

  reg_access_t access;
  readback_t   coreid_rb;
  readback_t   option_rb;

  // Bus decode, number latch and read mux
  port_access_ctrl u_ctrl (
    .sysclk    (sysclk),
    .reset     (reset),
    .bus       (bus),
    .coreid_rb (coreid_rb),
    .option_rb (option_rb),
    .access    (access),
    .din       (din),
    .oe        (oe)
  );

  coreid_reader #(
    .CORE_ID (CORE_ID)
  ) u_coreid (
    .sysclk (sysclk),
    .reset  (reset),
    .access (access),
    .rb     (coreid_rb)
  );

  option_registers u_options (
    .sysclk      (sysclk),
    .reset       (reset),
    .turbo_boost (turbo_boost),
    .access      (access),
    .rb          (option_rb),
    .video_opts  (video_opts),
    .device_opts (device_opts),
    .cpu_speed   (cpu_speed)
  );

endmodule

// File: test/port_access_ctrl_assert.sv
`timescale 1ns/1ps

module port_access_ctrl_assert (
  input logic                   sysclk,
  input logic                   reset,
  input zxuno_pkg::io_bus_t     bus_q,
  input zxuno_pkg::reg_access_t access,
  input logic                   oe
);

  int   fail_count;
  logic sampled_active;

  initial fail_count = 0;

  assign sampled_active = !bus_q.iorq_n && (bus_q.rd_n != bus_q.wr_n);

  strobe_exclusive: assert property (@(posedge sysclk) disable iff (reset)
    !(access.rd_stb && access.wr_stb))
    else begin
      $error("rd_stb and wr_stb high in the same cycle");
      fail_count++;
    end

  // One strobe per access
  rd_stb_single: assert property (@(posedge sysclk) disable iff (reset)
    access.rd_stb |=> !access.rd_stb)
    else begin
      $error("rd_stb high for two cycles");
      fail_count++;
    end

  wr_stb_single: assert property (@(posedge sysclk) disable iff (reset)
    access.wr_stb |=> !access.wr_stb)
    else begin
      $error("wr_stb high for two cycles");
      fail_count++;
    end

  oe_idle_low: assert property (@(posedge sysclk) disable iff (reset)
    !sampled_active |-> !oe)
    else begin
      $error("oe high while the sampled bus is inactive");
      fail_count++;
    end

  oe_reset_low: assert property (@(posedge sysclk) reset |=> !oe)
    else begin
      $error("oe high during reset");
      fail_count++;
    end

endmodule

bind port_access_ctrl port_access_ctrl_assert u_ctrl_assert (
  .sysclk (sysclk),
  .reset  (reset),
  .bus_q  (bus_q),
  .access (access),
  .oe     (oe)
);

// File: test/tb_zxuno_regs.sv
`timescale 1ns/1ps

module tb_zxuno_regs;
  import zxuno_pkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int RESET_CYCLES  = 8;
  localparam int ACTIVE_CYCLES = 4;
  localparam int IDLE_CYCLES   = 2;
  localparam int N_LATCH       = 16;
  localparam int N_REG         = 12;
  localparam int N_UNUSED      = 6;
  localparam int ID_READS      = CORE_ID_MAX + 2;
  localparam int N_ACCESSES    = 10 + 2*N_LATCH + 6*N_UNUSED + 6*N_REG + ID_READS;
  localparam int WATCHDOG_CYCLES =
    RESET_CYCLES + N_ACCESSES * (ACTIVE_CYCLES + IDLE_CYCLES) + 100;

  // Core ID handed to the DUT, same text kept for the model below
  localparam logic [CORE_ID_MAX*8-1:0] ID_BITS = "ZXUNO-EV2";

  logic         sysclk;
  logic         reset;
  io_bus_t      bus;
  logic         turbo_boost;
  logic [7:0]   din;
  logic         oe;
  video_opts_t  video_opts;
  device_opts_t device_opts;
  logic [1:0]   cpu_speed;

  logic [15:0]  lfsr;
  string        id_text = "ZXUNO-EV2";

  // Reference model state
  logic [7:0]   m_reg_num;
  logic [7:0]   m_scratch;
  logic [7:0]   m_scandbl;
  logic [7:0]   m_devopts;
  int           m_id_idx;

  int byte_errors;
  int oe_errors;
  int video_errors;
  int device_errors;
  int speed_errors;

  zxuno_regs_top #(
    .CORE_ID (ID_BITS)
  ) UUT (
    .sysclk      (sysclk),
    .reset       (reset),
    .bus         (bus),
    .turbo_boost (turbo_boost),
    .din         (din),
    .oe          (oe),
    .video_opts  (video_opts),
    .device_opts (device_opts),
    .cpu_speed   (cpu_speed)
  );

  always #(CLK_PERIOD/2) sysclk = ~sysclk;

  // ------------------------------
  // Random numbers
  // ------------------------------

  // 16 bit Galois LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  function automatic logic [7:0] random_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[6:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [7:0] unassigned_number();
    logic [7:0] v;
    v = random_bits(8);
    while (v == REG_SCANDBL || v == REG_DEVOPTS ||
           v == REG_SCRATCH || v == REG_COREID) begin
      v = random_bits(8);
    end
    return v;
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------

  task automatic model_write(input logic [15:0] addr, input logic [7:0] value);
    if (addr == ADDR_PORT) begin
      m_reg_num = value;
      m_id_idx  = 0;
    end else if (addr == DATA_PORT) begin
      case (m_reg_num)
        REG_SCRATCH: m_scratch = value;
        REG_SCANDBL: m_scandbl = value;
        REG_DEVOPTS: m_devopts = value;
        default: ;
      endcase
    end
  endtask

  task automatic model_read(input logic [15:0] addr, output logic [7:0] data,
                            output logic en);
    data = 8'hFF;
    en   = 1'b0;
    if (addr == ADDR_PORT) begin
      data = m_reg_num;
      en   = 1'b1;
    end else if (addr == DATA_PORT) begin
      en = 1'b1;
      case (m_reg_num)
        REG_COREID: begin
          data = (m_id_idx < id_text.len()) ? id_text[m_id_idx] : 8'h00;
          if (m_id_idx < CORE_ID_MAX) begin
            m_id_idx++;
          end
        end
        REG_SCRATCH: data = m_scratch;
        REG_SCANDBL: data = m_scandbl;
        REG_DEVOPTS: data = m_devopts;
        default: begin
          data = 8'hFF;
          en   = 1'b0;
        end
      endcase
    end
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: din expected %02h, actual %02h", name, exp, act);
      byte_errors++;
    end
  endtask

  task automatic check_oe(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Mismatch %s: oe expected %b, actual %b", name, exp, act);
      oe_errors++;
    end
  endtask

  task automatic check_video(input string name, input video_opts_t exp, input video_opts_t act);
    if (act !== exp) begin
      $display("Mismatch %s: video_opts expected %06b, actual %06b", name, exp, act);
      video_errors++;
    end
  endtask

  task automatic check_device(input string name, input device_opts_t exp,
                              input device_opts_t act);
    if (act !== exp) begin
      $display("Mismatch %s: device_opts expected %02h, actual %02h", name, exp, act);
      device_errors++;
    end
  endtask

  task automatic check_speed(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: cpu_speed expected %02b, actual %02b", name, exp, act);
      speed_errors++;
    end
  endtask

  // Option outputs against the bit map of registers 0B and 0E
  task automatic check_outputs(input string name);
    video_opts_t  exp_video;
    device_opts_t exp_dev;
    logic [1:0]   exp_speed;
    exp_video.vga_enable       = m_scandbl[0];
    exp_video.scanlines_enable = m_scandbl[1];
    exp_video.freq_option      = m_scandbl[4:2];
    exp_video.csync_option     = m_scandbl[5];
    exp_dev.disable_ay         = m_devopts[0];
    exp_dev.disable_turboay    = m_devopts[1];
    exp_dev.disable_7ffd       = m_devopts[2];
    exp_dev.disable_1ffd       = m_devopts[3];
    exp_dev.disable_romsel7f   = m_devopts[4];
    exp_dev.disable_romsel1f   = m_devopts[5];
    exp_dev.disable_spisd      = m_devopts[6];
    exp_dev.disable_ulaplus    = m_devopts[7];
    exp_speed = turbo_boost ? 2'b11 : m_scandbl[7:6];
    check_video(name, exp_video, video_opts);
    check_device(name, exp_dev, device_opts);
    check_speed(name, exp_speed, cpu_speed);
  endtask

  // ------------------------------
  // Bus accesses
  // ------------------------------

  task automatic bus_idle();
    bus = '{addr: 16'h0000, wdata: 8'h00, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic run_access(input string name, input logic [15:0] addr,
                            input logic is_write, input logic [7:0] value);
    logic [7:0] exp_data;
    logic       exp_oe;
    logic [7:0] got_data;
    logic       got_oe;
    bus = '{addr: addr, wdata: value, iorq_n: 1'b0, rd_n: is_write, wr_n: !is_write};
    repeat (ACTIVE_CYCLES) @(negedge sysclk);
    // Last falling edge before release
    got_data = din;
    got_oe   = oe;
    if (is_write) begin
      model_write(addr, value);
    end else begin
      model_read(addr, exp_data, exp_oe);
      check_byte(name, exp_data, got_data);
      check_oe(name, exp_oe, got_oe);
    end
    check_outputs(name);
    bus_idle();
    repeat (IDLE_CYCLES) @(negedge sysclk);
  endtask

  function automatic int total_errors();
    return byte_errors + oe_errors + video_errors + device_errors + speed_errors +
           UUT.u_ctrl.u_ctrl_assert.fail_count;
  endfunction

  task automatic print_error_counts();
    $display("Errors: din %0d, oe %0d, video %0d, device %0d, speed %0d, assertion %0d",
             byte_errors, oe_errors, video_errors, device_errors, speed_errors,
             UUT.u_ctrl.u_ctrl_assert.fail_count);
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------

  initial begin
    logic [7:0] value;
    sysclk      = 1'b0;
    reset       = 1'b1;
    turbo_boost = 1'b0;
    bus_idle();
    lfsr          = 16'd62090;
    m_reg_num     = 8'h00;
    m_scratch     = 8'h00;
    m_scandbl     = 8'h00;
    m_devopts     = 8'h00;
    m_id_idx      = 0;
    byte_errors   = 0;
    oe_errors     = 0;
    video_errors  = 0;
    device_errors = 0;
    speed_errors  = 0;
    repeat (RESET_CYCLES) @(negedge sysclk);
    reset = 1'b0;

    // Reset values
    check_byte("reset din", 8'hFF, din);
    check_oe("reset oe", 1'b0, oe);
    run_access("reset read", DATA_PORT, 1'b0, 8'h00);

    // Register number latch
    for (int i = 0; i < N_LATCH; i++) begin
      value = random_bits(8);
      run_access($sformatf("latch write %0d", i), ADDR_PORT, 1'b1, value);
      run_access($sformatf("latch read %0d", i), ADDR_PORT, 1'b0, 8'h00);
    end
    for (int i = 0; i < N_UNUSED; i++) begin
      run_access($sformatf("unassigned select %0d", i), ADDR_PORT, 1'b1, unassigned_number());
      run_access($sformatf("unassigned read %0d", i), DATA_PORT, 1'b0, 8'h00);
    end

    // Scratch register, then writes that must land nowhere
    run_access("scratch select", ADDR_PORT, 1'b1, REG_SCRATCH);
    for (int i = 0; i < N_REG; i++) begin
      run_access($sformatf("scratch write %0d", i), DATA_PORT, 1'b1, random_bits(8));
      run_access($sformatf("scratch read %0d", i), DATA_PORT, 1'b0, 8'h00);
    end
    for (int i = 0; i < N_UNUSED; i++) begin
      run_access($sformatf("stray select %0d", i), ADDR_PORT, 1'b1, unassigned_number());
      run_access($sformatf("stray write %0d", i), DATA_PORT, 1'b1, random_bits(8));
      run_access($sformatf("stray reselect %0d", i), ADDR_PORT, 1'b1, REG_SCRATCH);
      run_access($sformatf("stray check %0d", i), DATA_PORT, 1'b0, 8'h00);
    end

    // Scan doubler and speed, turbo key toggled at random
    run_access("scandbl select", ADDR_PORT, 1'b1, REG_SCANDBL);
    for (int i = 0; i < N_REG; i++) begin
      turbo_boost = (random_bits(1) != 8'h00);
      run_access($sformatf("scandbl write %0d", i), DATA_PORT, 1'b1, random_bits(8));
      run_access($sformatf("scandbl read %0d", i), DATA_PORT, 1'b0, 8'h00);
    end
    turbo_boost = 1'b1;
    run_access("scandbl turbo read", DATA_PORT, 1'b0, 8'h00);
    turbo_boost = 1'b0;

    // Device options
    run_access("devopts select", ADDR_PORT, 1'b1, REG_DEVOPTS);
    for (int i = 0; i < N_REG; i++) begin
      run_access($sformatf("devopts write %0d", i), DATA_PORT, 1'b1, random_bits(8));
      run_access($sformatf("devopts read %0d", i), DATA_PORT, 1'b0, 8'h00);
    end

    // Core ID string, past its end and restarted by a rewrite
    run_access("coreid select", ADDR_PORT, 1'b1, REG_COREID);
    for (int i = 0; i < ID_READS; i++) begin
      run_access($sformatf("coreid read %0d", i), DATA_PORT, 1'b0, 8'h00);
    end
    run_access("coreid reselect", ADDR_PORT, 1'b1, REG_COREID);
    for (int i = 0; i < 3; i++) begin
      run_access($sformatf("coreid restart %0d", i), DATA_PORT, 1'b0, 8'h00);
    end

    print_error_counts();
    if (total_errors() == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    print_error_counts();
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: list.f
source/zxuno_pkg.sv
source/port_access_ctrl.sv
source/coreid_reader.sv
source/option_registers.sv
source/zxuno_regs_top.sv
test/port_access_ctrl_assert.sv
test/tb_zxuno_regs.sv
